// ==== mempool_pkg.sv ====
// MemPool system package
// Bus widths, address map, control register offsets and target encoding
package mempool_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned ByteOffset = $clog2(StrbWidth); // Byte bits below the word index

  localparam int unsigned NumCores = 4;

  // L2 data memory, 1 KiB
  localparam int unsigned L2NumWords = 256;
  localparam int unsigned L2AddrWidth = $clog2(L2NumWords);
  localparam logic [AddrWidth-1:0] L2BaseAddr = 32'h8000_0000;
  localparam logic [AddrWidth-1:0] L2EndAddr =
    L2BaseAddr + AddrWidth'(L2NumWords * StrbWidth); // Exclusive

  // Boot ROM, 16 words
  localparam int unsigned BootromNumWords = 16;
  localparam int unsigned BootromAddrWidth = $clog2(BootromNumWords);
  localparam logic [AddrWidth-1:0] BootromBaseAddr = 32'hA000_0000;
  localparam logic [AddrWidth-1:0] BootromEndAddr =
    BootromBaseAddr + AddrWidth'(BootromNumWords * StrbWidth); // Exclusive

  // Control registers
  localparam logic [AddrWidth-1:0] CtrlBaseAddr = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] CtrlEndAddr = 32'h4000_FFFF; // Inclusive
  localparam int unsigned CtrlOffsetWidth = 16;

  localparam logic [CtrlOffsetWidth-1:0] EocOffset = 16'h0000;
  localparam logic [CtrlOffsetWidth-1:0] WakeUpOffset = 16'h0004;
  localparam logic [CtrlOffsetWidth-1:0] TcdmStartOffset = 16'h0008;
  localparam logic [CtrlOffsetWidth-1:0] TcdmEndOffset = 16'h000C;
  localparam logic [CtrlOffsetWidth-1:0] NumCoresOffset = 16'h0010;

  // Cluster local memory, reported through the control block
  localparam logic [AddrWidth-1:0] TCDMBaseAddr = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] TCDMSize = 32'h0010_0000;

  // Which target serves an access
  typedef enum logic [1:0] {
    TgtCtrl,
    TgtL2,
    TgtBootrom,
    TgtNone // Unmapped address or write to ROM
  } target_e;

endpackage : mempool_pkg

// ==== addr_decoder.sv ====
// Address decoder
// Classifies each host access by address range and raises one target strobe
module addr_decoder
  import mempool_pkg::*;
(
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  output logic                 ctrl_req_o,
  output logic                 l2_req_o,
  output logic                 rom_req_o,
  output target_e              tgt_o
);

  logic in_ctrl;
  logic in_l2;
  logic in_rom;

  // Range checks
  assign in_ctrl = (addr_i >= CtrlBaseAddr) && (addr_i <= CtrlEndAddr);
  assign in_l2   = (addr_i >= L2BaseAddr) && (addr_i < L2EndAddr);
  assign in_rom  = (addr_i >= BootromBaseAddr) && (addr_i < BootromEndAddr);

  always_comb begin
    tgt_o = TgtNone;
    if (in_ctrl) begin
      tgt_o = TgtCtrl;
    end else if (in_l2) begin
      tgt_o = TgtL2;
    end else if (in_rom && !we_i) begin
      tgt_o = TgtBootrom; // ROM only answers reads
    end
  end

  // Strobes only while the host requests
  assign ctrl_req_o = req_i && (tgt_o == TgtCtrl);
  assign l2_req_o   = req_i && (tgt_o == TgtL2);
  assign rom_req_o  = req_i && (tgt_o == TgtBootrom);

endmodule : addr_decoder

// ==== l2_mem.sv ====
// L2 data memory
// Single-port word array with byte-enable writes and registered read data
module l2_mem
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [StrbWidth-1:0] strb_i,
  output logic [DataWidth-1:0] rdata_o
);

  logic [DataWidth-1:0]   mem_q [L2NumWords];
  logic [L2AddrWidth-1:0] word_idx;

  assign word_idx = addr_i[ByteOffset +: L2AddrWidth]; // Range check done by the decoder

  // Write path, one byte lane per strobe bit
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (strb_i[b]) begin
          mem_q[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Read port returns the word before this cycle's update
  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= we_i ? '0 : mem_q[word_idx];
    end
  end

endmodule : l2_mem

// ==== bootrom.sv ====
// Boot ROM
// Read-only word array filled from bootrom.hex, registered read data
module bootrom
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 req_i,
  input  logic [AddrWidth-1:0] addr_i,
  output logic [DataWidth-1:0] rdata_o
);

  logic [DataWidth-1:0]        rom [BootromNumWords];
  logic [BootromAddrWidth-1:0] word_idx;

  initial begin
    $readmemh("bootrom.hex", rom); // Boot image
  end

  assign word_idx = addr_i[ByteOffset +: BootromAddrWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rom[word_idx];
    end
  end

endmodule : bootrom

// ==== ctrl_registers.sv ====
// Control registers
// End-of-computation word, core wake-up pulses and read-only cluster facts
module ctrl_registers
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic [NumCores-1:0]  wake_up_o,
  output logic                 eoc_valid_o
);

  logic [CtrlOffsetWidth-1:0] offset;
  logic [DataWidth-1:0]       eoc_q;
  logic [DataWidth-1:0]       read_val;
  logic                       wr_en;
  logic                       wake_fire;

  assign offset    = addr_i[CtrlOffsetWidth-1:0]; // Base is 64 KiB aligned
  assign wr_en     = req_i && we_i;
  assign wake_fire = wr_en && (offset == WakeUpOffset);

  // Writable state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      eoc_q     <= '0;
      wake_up_o <= '0;
    end else begin
      wake_up_o <= '0; // Pulse lasts one cycle
      if (wr_en && (offset == EocOffset)) begin
        eoc_q <= wdata_i;
      end
      if (wake_fire) begin
        wake_up_o <= wdata_i[NumCores-1:0];
      end
    end
  end

  assign eoc_valid_o = eoc_q[0];

  // Read values, read-only offsets ignore writes
  always_comb begin
    case (offset)
      EocOffset:       read_val = eoc_q;
      WakeUpOffset:    read_val = '0;
      TcdmStartOffset: read_val = TCDMBaseAddr;
      TcdmEndOffset:   read_val = TCDMBaseAddr + TCDMSize;
      NumCoresOffset:  read_val = DataWidth'(NumCores);
      default:         read_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= we_i ? '0 : read_val; // Writes acknowledge with zero
    end
  end

  // Back-to-back pulses need a wake-up write on each of the two edges before
  assert property (@(posedge clk_i) disable iff (rst_i)
    (|wake_up_o && $past(|wake_up_o)) |-> ($past(wake_fire) && $past(wake_fire, 2)))
    else $error("ctrl_registers: wake-up held without consecutive writes");

endmodule : ctrl_registers

// ==== resp_mux.sv ====
// Response stage
// Registers the answering target one cycle, then returns data, valid and error
module resp_mux
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  target_e              tgt_i,
  input  logic [DataWidth-1:0] ctrl_rdata_i,
  input  logic [DataWidth-1:0] l2_rdata_i,
  input  logic [DataWidth-1:0] rom_rdata_i,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o
);

  logic    valid_q;
  target_e tgt_q;

  // At most one access in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
      tgt_q   <= TgtNone;
    end else begin
      valid_q <= req_i;
      tgt_q   <= tgt_i;
    end
  end

  // Targets already hold their registered data
  always_comb begin
    case (tgt_q)
      TgtCtrl:    rdata_o = ctrl_rdata_i;
      TgtL2:      rdata_o = l2_rdata_i;
      TgtBootrom: rdata_o = rom_rdata_i;
      default:    rdata_o = '0; // Error response
    endcase
  end

  assign rvalid_o = valid_q;
  assign err_o    = valid_q && (tgt_q == TgtNone);

  // A valid response never carries unknown data, such as an unwritten L2 word
  assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> !$isunknown(rdata_o))
    else $error("resp_mux: valid response with unknown data");

endmodule : resp_mux

// ==== mempool_system.sv ====
// MemPool system wrapper
// Host port decoded onto L2, boot ROM and control registers, one-cycle response
module mempool_system
  import mempool_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Host request
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [StrbWidth-1:0] strb_i,
  // Host response
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,
  // Cluster side
  output logic [NumCores-1:0]  wake_up_o,
  output logic                 eoc_valid_o
);

  logic                 ctrl_req;
  logic                 l2_req;
  logic                 rom_req;
  target_e              tgt;
  logic [DataWidth-1:0] ctrl_rdata;
  logic [DataWidth-1:0] l2_rdata;
  logic [DataWidth-1:0] rom_rdata;

  addr_decoder i_addr_decoder (
    .req_i     (req_i   ),
    .we_i      (we_i    ),
    .addr_i    (addr_i  ),
    .ctrl_req_o(ctrl_req),
    .l2_req_o  (l2_req  ),
    .rom_req_o (rom_req ),
    .tgt_o     (tgt     )
  );

  l2_mem i_l2_mem (
    .clk_i  (clk_i   ),
    .req_i  (l2_req  ),
    .we_i   (we_i    ),
    .addr_i (addr_i  ),
    .wdata_i(wdata_i ),
    .strb_i (strb_i  ),
    .rdata_o(l2_rdata)
  );

  bootrom i_bootrom (
    .clk_i  (clk_i    ),
    .req_i  (rom_req  ),
    .addr_i (addr_i   ),
    .rdata_o(rom_rdata)
  );

  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (ctrl_req   ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .rdata_o    (ctrl_rdata ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  resp_mux i_resp_mux (
    .clk_i       (clk_i     ),
    .rst_i       (rst_i     ),
    .req_i       (req_i     ),
    .tgt_i       (tgt       ),
    .ctrl_rdata_i(ctrl_rdata),
    .l2_rdata_i  (l2_rdata  ),
    .rom_rdata_i (rom_rdata ),
    .rvalid_o    (rvalid_o  ),
    .rdata_o     (rdata_o   ),
    .err_o       (err_o     )
  );

endmodule : mempool_system

// ==== tb_mempool_system.sv ====
// Testbench for the MemPool system
// Reference model of the address map, directed and random accesses, per-cycle compare
module tb_mempool_system
  import mempool_pkg::*;
();

  localparam int ClkPeriod      = 10;
  localparam int ResetCycles    = 5;
  localparam int DirectedCycles = 128; // Upper bound on directed accesses and idles
  localparam int RandomAccesses = 300;
  localparam int TestCycles     =
    ResetCycles + int'(L2NumWords) + DirectedCycles + RandomAccesses;

  logic                 clk_i = 1'b0;
  logic                 rst_i;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [DataWidth-1:0] wdata_i;
  logic [StrbWidth-1:0] strb_i;
  logic                 rvalid_o;
  logic [DataWidth-1:0] rdata_o;
  logic                 err_o;
  logic [NumCores-1:0]  wake_up_o;
  logic                 eoc_valid_o;

  // Expected outputs for the cycle after a request edge
  typedef struct packed {
    logic                 valid;
    logic                 err;
    logic [DataWidth-1:0] rdata;
    logic                 eoc;
    logic [NumCores-1:0]  wake;
  } expect_t;

  logic [DataWidth-1:0] l2_shadow  [L2NumWords];
  logic [DataWidth-1:0] rom_shadow [BootromNumWords];
  logic [DataWidth-1:0] eoc_shadow;
  expect_t              exp_q [$];
  int                   seed        = 32'hf1f3;
  int                   issued      = 0;
  int                   checks_done = 0;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  mempool_system UUT (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_i      (req_i      ),
    .we_i       (we_i       ),
    .addr_i     (addr_i     ),
    .wdata_i    (wdata_i    ),
    .strb_i     (strb_i     ),
    .rvalid_o   (rvalid_o   ),
    .rdata_o    (rdata_o    ),
    .err_o      (err_o      ),
    .wake_up_o  (wake_up_o  ),
    .eoc_valid_o(eoc_valid_o)
  );

  // Address map
  function automatic logic is_ctrl(input logic [AddrWidth-1:0] addr);
    return (addr >= CtrlBaseAddr) && (addr <= CtrlEndAddr);
  endfunction

  function automatic logic is_l2(input logic [AddrWidth-1:0] addr);
    return (addr >= L2BaseAddr) && (addr < L2BaseAddr + 32'h0000_0400); // 1 KiB
  endfunction

  function automatic logic is_rom(input logic [AddrWidth-1:0] addr);
    return (addr >= BootromBaseAddr) && (addr < BootromBaseAddr + 32'h0000_0040);
  endfunction

  // Expected {err, rdata} of one access before the access changes the model
  function automatic logic [DataWidth:0] ref_response(input logic we,
                                                      input logic [AddrWidth-1:0] addr);
    logic [DataWidth-1:0] data;
    logic                 err;
    data = '0;
    err  = 1'b0;
    if (is_ctrl(addr)) begin
      if (!we) begin
        case (addr[15:0])
          EocOffset:       data = eoc_shadow;
          TcdmStartOffset: data = TCDMBaseAddr;
          TcdmEndOffset:   data = TCDMBaseAddr + TCDMSize;
          NumCoresOffset:  data = 32'(NumCores);
          default:         data = '0; // Wake-up and unused offsets
        endcase
      end
    end else if (is_l2(addr)) begin
      if (!we) begin
        data = l2_shadow[addr[9:2]];
      end
    end else if (is_rom(addr) && !we) begin
      data = rom_shadow[addr[5:2]];
    end else begin
      err = 1'b1; // Unmapped, or a write to the ROM
    end
    return {err, data};
  endfunction

  // Applies a write to the shadow state and returns the expected wake-up pulse
  task automatic update_model(input logic we, input logic [AddrWidth-1:0] addr,
                              input logic [DataWidth-1:0] wdata,
                              input logic [StrbWidth-1:0] strb,
                              output logic [NumCores-1:0] wake);
    wake = '0;
    if (we && is_l2(addr)) begin
      for (int b = 0; b < int'(StrbWidth); b++) begin
        if (strb[b]) begin
          l2_shadow[addr[9:2]][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
    end else if (we && is_ctrl(addr)) begin
      if (addr[15:0] == EocOffset) begin
        eoc_shadow = wdata;
      end
      if (addr[15:0] == WakeUpOffset) begin
        wake = wdata[NumCores-1:0];
      end
    end
  endtask

  task automatic issue(input logic we, input logic [AddrWidth-1:0] addr,
                       input logic [DataWidth-1:0] wdata,
                       input logic [StrbWidth-1:0] strb);
    logic [DataWidth:0]  resp;
    logic [NumCores-1:0] wake;
    expect_t             e;
    resp = ref_response(we, addr);
    update_model(we, addr, wdata, strb, wake);
    e.valid = 1'b1;
    e.err   = resp[DataWidth];
    e.rdata = resp[DataWidth-1:0];
    e.eoc   = eoc_shadow[0];
    e.wake  = wake;
    exp_q.push_back(e);
    issued++;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    strb_i  = strb;
    @(negedge clk_i);
  endtask

  task automatic write_word(input logic [AddrWidth-1:0] addr,
                            input logic [DataWidth-1:0] data,
                            input logic [StrbWidth-1:0] strb);
    issue(1'b1, addr, data, strb);
  endtask

  task automatic read_word(input logic [AddrWidth-1:0] addr);
    issue(1'b0, addr, '0, '0);
  endtask

  // One cycle without a request
  task automatic idle();
    expect_t e;
    e     = '0;
    e.eoc = eoc_shadow[0];
    exp_q.push_back(e);
    issued++;
    req_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic compare_values(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Multiplicative hash so that every address bit reaches the word
  function automatic logic [DataWidth-1:0] fill_pattern(input logic [AddrWidth-1:0] addr);
    return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};
  endfunction

  always begin : compare_proc
    expect_t e;
    @(posedge clk_i);
    #1; // Registered outputs have settled
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      compare_values("rvalid_o", 32'(rvalid_o), 32'(e.valid));
      compare_values("err_o", 32'(err_o), 32'(e.err));
      if (e.valid) begin
        compare_values("rdata_o", rdata_o, e.rdata);
      end
      compare_values("eoc_valid_o", 32'(eoc_valid_o), 32'(e.eoc));
      compare_values("wake_up_o", 32'(wake_up_o), 32'(e.wake));
      checks_done++;
    end
  end

  initial begin : watchdog
    #(TestCycles * ClkPeriod + 100 * ClkPeriod);
    $display("Error: simulation timed out at %0t before all accesses finished", $time);
    $display("Some tests failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin : stimulus
    logic [DataWidth-1:0] rnd;
    logic [DataWidth-1:0] data;
    logic [AddrWidth-1:0] addr;
    rst_i   = 1'b1;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    strb_i  = '0;
    eoc_shadow = '0;
    $readmemh("bootrom.hex", rom_shadow);
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    // Quiet outputs after reset, then the fixed cluster facts
    idle();
    read_word(CtrlBaseAddr + 32'(TcdmStartOffset));
    read_word(CtrlBaseAddr + 32'(TcdmEndOffset));
    read_word(CtrlBaseAddr + 32'(NumCoresOffset));

    // Fill the L2 so every later read is defined
    for (int i = 0; i < int'(L2NumWords); i++) begin
      addr = L2BaseAddr + 32'(i * 4);
      write_word(addr, fill_pattern(addr), '1);
    end

    // Partial writes that are read back on the very next cycle
    for (int i = 0; i < 16; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      addr = L2BaseAddr + {22'b0, rnd[9:2], 2'b00};
      write_word(addr, data, rnd[13:10]);
      read_word(addr);
    end
    idle();

    for (int i = 0; i < int'(BootromNumWords); i++) begin
      read_word(BootromBaseAddr + 32'(i * 4));
    end
    write_word(BootromBaseAddr + 32'h8, 32'hDEAD_BEEF, '1); // ROM is read-only
    read_word(32'h0000_0000);                                // TCDM not on this port
    write_word(32'h4001_0000, 32'h1111_2222, '1);            // Just past the control block
    read_word(L2BaseAddr + 32'h400);
    read_word(BootromBaseAddr + 32'h40);
    read_word(32'hFFFF_FFFC);
    read_word(BootromBaseAddr + 32'h8);
    idle();

    // End of computation flag follows bit 0
    write_word(CtrlBaseAddr + 32'(EocOffset), 32'h1234_5679, '1);
    idle();
    read_word(CtrlBaseAddr + 32'(EocOffset));
    write_word(CtrlBaseAddr + 32'(EocOffset), 32'hABCD_0002, '1);
    idle();
    read_word(CtrlBaseAddr + 32'(EocOffset));

    write_word(CtrlBaseAddr + 32'(WakeUpOffset), 32'h0000_00F5, '1);
    idle();
    read_word(CtrlBaseAddr + 32'(WakeUpOffset));
    write_word(CtrlBaseAddr + 32'(WakeUpOffset), 32'h0000_0003, '1);
    write_word(CtrlBaseAddr + 32'(WakeUpOffset), 32'h0000_000C, '1); // Back-to-back pulses
    idle();
    write_word(CtrlBaseAddr + 32'(TcdmStartOffset), 32'hFFFF_FFFF, '1);
    read_word(CtrlBaseAddr + 32'(TcdmStartOffset));
    idle();

    // Random mix over all ranges
    for (int i = 0; i < RandomAccesses; i++) begin
      rnd  = $random(seed);
      data = $random(seed);
      case (rnd[2:0])
        3'd0, 3'd1, 3'd2: addr = L2BaseAddr + {22'b0, rnd[15:8], 2'b00};
        3'd3:             addr = BootromBaseAddr + {26'b0, rnd[11:8], 2'b00};
        3'd4, 3'd5:       addr = CtrlBaseAddr + {27'b0, rnd[10:8], 2'b00}; // Up to 0x1C
        default:          addr = $random(seed); // Mostly unmapped
      endcase
      issue(rnd[3], addr, data, rnd[7:4]);
    end
    idle();

    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    if (checks_done != issued) begin
      $display("Error: only %0d of %0d expected responses were checked",
               checks_done, issued);
    end
    if (checks_done == issued) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_mempool_system

// ==== bootrom.hex ====
// One 32-bit boot word per line, word 0 first
f1402573
00000297
03c28293
00050463
10500073
80000337
00032383
000380e7
40000e37
00100f13
01ee2023
0000006f
00000013
00000013
deadbeef
cafef00d

// ==== files.f ====
mempool_pkg.sv
addr_decoder.sv
l2_mem.sv
bootrom.sv
ctrl_registers.sv
resp_mux.sv
mempool_system.sv
tb_mempool_system.sv

// ==== Makefile ====
# Verilator build and run of the MemPool system testbench
SRCS := $(shell cat files.f)
BIN  := obj_dir/Vtb_mempool_system

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

$(BIN): files.f $(SRCS)
	verilator --binary --timing --assert -f files.f --top-module tb_mempool_system \
		-o Vtb_mempool_system

clean:
	rm -rf obj_dir
